/* logic/mac_tx_pkg.sv */
package mac_tx_pkg;

    ////////////////////
    // frame format
    ////////////////////

    // length field taken from the pointer word
    localparam int len_w = 12;

    // gmii preamble and start of frame delimiter
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hd5;

    // preamble bytes before the sfd
    localparam int preamble_len = 7;
    // fcs length
    localparam int crc_bytes    = 4;
    // idle cycles between frames
    localparam int ifg_len      = 12;

    ////////////////////
    // crc-32, 802.3
    ////////////////////

    // bit reversed form of 04c11db7
    localparam logic [31:0] crc_poly_refl = 32'hedb8_8320;
    localparam logic [31:0] crc_init_val  = 32'hffff_ffff;

    ////////////////////
    // management word
    ////////////////////

    // queue flag inside the 4-bit flag nibble
    localparam int mgnt_tte_bit = 3;

    // queue arbiter states
    typedef enum logic [1:0] {
        arb_idle,
        arb_ptr_read,
        arb_ptr_take,
        arb_busy
    } arb_state_t;

    // transmit sequencer states
    typedef enum logic [2:0] {
        seq_idle,
        seq_preamble,
        seq_sfd,
        seq_payload,
        seq_crc,
        seq_gap
    } seq_state_t;

endpackage

/* logic/crc32_gen.sv */
`timescale 1ns/1ps

module crc32_gen (
    input  logic       interface_clk,
    input  logic       rstn_mac,
    input  logic       crc_clear,
    input  logic       crc_update,
    input  logic       crc_shift,
    input  logic [7:0] crc_din,
    output logic [7:0] crc_byte
);
    import mac_tx_pkg::*;

    logic [31:0] crc_q;

    // one byte through the reflected lfsr, lsb first
    function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] din);
        logic [31:0] c;
        c = crc ^ {24'h0, din};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly_refl;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_q <= crc_init_val;
        end else if (crc_clear) begin
            crc_q <= crc_init_val;
        end else if (crc_update) begin
            crc_q <= crc_next(crc_q, crc_din);
        end else if (crc_shift) begin
            // next fcs byte down to the output
            crc_q <= {8'h00, crc_q[31:8]};
        end
    end

    // fcs goes out inverted
    assign crc_byte = ~crc_q[7:0];

endmodule

/* logic/tx_queue_arbiter.sv */
`timescale 1ns/1ps

module tx_queue_arbiter (
    input  logic                         interface_clk,
    input  logic                         rstn_mac,
    // pointer fifos, length in the low bits
    input  logic [15:0]                  ptr_fifo_din,
    input  logic                         ptr_fifo_empty,
    input  logic [15:0]                  tptr_fifo_din,
    input  logic                         tptr_fifo_empty,
    // data fifos, registered output
    input  logic [7:0]                   data_fifo_din,
    input  logic [7:0]                   tdata_fifo_din,
    // from sequencer and report block
    input  logic                         byte_rd,
    input  logic                         frame_done,
    input  logic                         mgnt_busy,
    // fifo read strobes
    output logic                         ptr_fifo_rd,
    output logic                         tptr_fifo_rd,
    output logic                         data_fifo_rd,
    output logic                         tdata_fifo_rd,
    // frame hand-off
    output logic                         frame_start,
    output logic                         frame_tte,
    output logic [mac_tx_pkg::len_w-1:0] frame_len,
    output logic [7:0]                   byte_data
);
    import mac_tx_pkg::*;

    arb_state_t state;
    // queue latched at pickup, 1 for tte
    logic       tte_sel;

    ////////////////////
    // pointer pickup
    ////////////////////

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state        <= arb_idle;
            tte_sel      <= 1'b0;
            ptr_fifo_rd  <= 1'b0;
            tptr_fifo_rd <= 1'b0;
            frame_start  <= 1'b0;
            frame_len    <= '0;
        end else begin
            case (state)
                arb_idle: begin
                    // hold off while last report is still pending
                    if (!mgnt_busy && (!ptr_fifo_empty || !tptr_fifo_empty)) begin
                        // tte has strict priority
                        tte_sel      <= !tptr_fifo_empty;
                        tptr_fifo_rd <= !tptr_fifo_empty;
                        ptr_fifo_rd  <= tptr_fifo_empty;
                        state        <= arb_ptr_read;
                    end
                end
                arb_ptr_read: begin
                    // one cycle strobe only
                    ptr_fifo_rd  <= 1'b0;
                    tptr_fifo_rd <= 1'b0;
                    state        <= arb_ptr_take;
                end
                arb_ptr_take: begin
                    // pointer word now on fifo output
                    frame_len   <= tte_sel ? tptr_fifo_din[len_w-1:0]
                                           : ptr_fifo_din[len_w-1:0];
                    frame_start <= 1'b1;
                    state       <= arb_busy;
                end
                arb_busy: begin
                    frame_start <= 1'b0;
                    // wait for gap to finish
                    if (frame_done) begin
                        state <= arb_idle;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    ////////////////////
    // payload routing
    ////////////////////

    // byte reads go to the latched queue only
    assign data_fifo_rd  = byte_rd && !tte_sel;
    assign tdata_fifo_rd = byte_rd && tte_sel;

    // matching fifo output back to sequencer
    assign byte_data = tte_sel ? tdata_fifo_din : data_fifo_din;

    // queue flag for the report word
    assign frame_tte = tte_sel;

endmodule

/* logic/tx_frame_sequencer.sv */
`timescale 1ns/1ps

module tx_frame_sequencer (
    input  logic                         interface_clk,
    input  logic                         rstn_mac,
    input  logic                         frame_start,
    input  logic [mac_tx_pkg::len_w-1:0] frame_len,
    input  logic [7:0]                   byte_data,
    output logic                         byte_rd,
    output logic                         frame_done,
    output logic                         gtx_dv,
    output logic [7:0]                   gtx_d
);
    import mac_tx_pkg::*;

    seq_state_t       state;
    // shared count for preamble, payload, crc and gap
    logic [len_w-1:0] cnt;
    // frame length held for the whole frame
    logic [len_w-1:0] len_q;
    logic             crc_clear;
    logic             crc_update;
    logic             crc_shift;
    logic [7:0]       crc_byte;

    ////////////////////
    // sequencing
    ////////////////////

    // state of a cycle picks the byte gtx_d shows one cycle later
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state  <= seq_idle;
            cnt    <= '0;
            len_q  <= '0;
            gtx_dv <= 1'b0;
            gtx_d  <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (frame_start) begin
                        // first preamble byte loaded right away
                        len_q  <= frame_len;
                        cnt    <= len_w'(1);
                        gtx_dv <= 1'b1;
                        gtx_d  <= preamble_byte;
                        state  <= seq_preamble;
                    end
                end
                seq_preamble: begin
                    gtx_d <= preamble_byte;
                    if (cnt == len_w'(preamble_len - 1)) begin
                        cnt   <= '0;
                        state <= seq_sfd;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                seq_sfd: begin
                    // first payload read issued here
                    gtx_d <= sfd_byte;
                    state <= seq_payload;
                end
                seq_payload: begin
                    gtx_d <= byte_data;
                    if (cnt == len_q - 1'b1) begin
                        cnt   <= '0;
                        state <= seq_crc;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                seq_crc: begin
                    // fcs, lsb first
                    gtx_d <= crc_byte;
                    if (cnt == len_w'(crc_bytes - 1)) begin
                        cnt   <= '0;
                        state <= seq_gap;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                seq_gap: begin
                    gtx_dv <= 1'b0;
                    gtx_d  <= '0;
                    if (cnt == len_w'(ifg_len)) begin
                        cnt   <= '0;
                        state <= seq_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // one read per payload byte, no read after the last one
    assign byte_rd = (state == seq_sfd) || ((state == seq_payload) && (cnt != len_q - 1'b1));

    // last of ifg_len low cycles on gtx_dv
    assign frame_done = (state == seq_gap) && (cnt == len_w'(ifg_len));

    ////////////////////
    // fcs
    ////////////////////

    assign crc_clear  = (state == seq_idle);
    assign crc_update = (state == seq_payload);
    assign crc_shift  = (state == seq_crc);

    crc32_gen u_crc32_gen (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .crc_clear     (crc_clear),
        .crc_update    (crc_update),
        .crc_shift     (crc_shift),
        .crc_din       (byte_data),
        .crc_byte      (crc_byte)
    );

endmodule

/* logic/tx_mgnt_report.sv */
`timescale 1ns/1ps

module tx_mgnt_report (
    input  logic                         interface_clk,
    input  logic                         rstn_mac,
    input  logic                         frame_start,
    input  logic [mac_tx_pkg::len_w-1:0] frame_len,
    input  logic                         frame_tte,
    input  logic                         tx_mgnt_resp,
    output logic                         tx_mgnt_valid,
    output logic [15:0]                  tx_mgnt_data,
    output logic                         mgnt_busy
);
    import mac_tx_pkg::*;

    logic [3:0] flag;

    // only the queue flag is defined for tx
    always_comb begin
        flag               = '0;
        flag[mgnt_tte_bit] = frame_tte;
    end

    // valid from frame start until response seen
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            tx_mgnt_valid <= 1'b0;
        end else if (frame_start) begin
            tx_mgnt_valid <= 1'b1;
        end else if (tx_mgnt_resp) begin
            tx_mgnt_valid <= 1'b0;
        end
    end

    // report word, flags over length
    always_ff @(posedge interface_clk) begin
        if (frame_start) begin
            tx_mgnt_data <= {flag, frame_len};
        end
    end

    // arbiter waits on the same interval
    assign mgnt_busy = tx_mgnt_valid;

endmodule

/* logic/mac_tx_gmii.sv */
`timescale 1ns/1ps

module mac_tx_gmii (
    input  logic        interface_clk,
    input  logic        rstn_mac,
    // gmii transmit
    output logic        gtx_dv,
    output logic [7:0]  gtx_d,
    // best effort queue
    output logic        data_fifo_rd,
    input  logic [7:0]  data_fifo_din,
    output logic        ptr_fifo_rd,
    input  logic [15:0] ptr_fifo_din,
    input  logic        ptr_fifo_empty,
    // tte queue
    output logic        tdata_fifo_rd,
    input  logic [7:0]  tdata_fifo_din,
    output logic        tptr_fifo_rd,
    input  logic [15:0] tptr_fifo_din,
    input  logic        tptr_fifo_empty,
    // management
    output logic        tx_mgnt_valid,
    output logic [15:0] tx_mgnt_data,
    input  logic        tx_mgnt_resp
);
    import mac_tx_pkg::*;

    // frame hand-off
    logic             frame_start;
    logic [len_w-1:0] frame_len;
    logic             frame_tte;
    logic             frame_done;
    // payload path
    logic             byte_rd;
    logic [7:0]       byte_data;
    logic             mgnt_busy;

    tx_queue_arbiter u_arbiter (
        .interface_clk   (interface_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_empty (tptr_fifo_empty),
        .data_fifo_din   (data_fifo_din),
        .tdata_fifo_din  (tdata_fifo_din),
        .byte_rd         (byte_rd),
        .frame_done      (frame_done),
        .mgnt_busy       (mgnt_busy),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .data_fifo_rd    (data_fifo_rd),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .frame_start     (frame_start),
        .frame_tte       (frame_tte),
        .frame_len       (frame_len),
        .byte_data       (byte_data)
    );

    tx_frame_sequencer u_sequencer (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .frame_start   (frame_start),
        .frame_len     (frame_len),
        .byte_data     (byte_data),
        .byte_rd       (byte_rd),
        .frame_done    (frame_done),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

    tx_mgnt_report u_mgnt_report (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .frame_start   (frame_start),
        .frame_len     (frame_len),
        .frame_tte     (frame_tte),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data),
        .mgnt_busy     (mgnt_busy)
    );

endmodule

/* tests/mac_tx_gmii_assertions.sv */
`timescale 1ns/1ps

module mac_tx_gmii_assertions (
    input logic interface_clk,
    input logic rstn_mac,
    input logic data_fifo_rd,
    input logic tdata_fifo_rd,
    input logic gtx_dv,
    input logic tx_mgnt_valid,
    input logic tx_mgnt_resp
);

    // payload reads go to one queue only
    a_one_data_read: assert property (
        @(posedge interface_clk) disable iff (!rstn_mac)
        !(data_fifo_rd && tdata_fifo_rd)
    ) else $error("data_fifo_rd and tdata_fifo_rd high together");

    // no transmit while in reset
    a_dv_in_reset: assert property (
        @(posedge interface_clk) !rstn_mac |-> !gtx_dv
    ) else $error("gtx_dv high during reset");

    // report drops only after the response
    a_valid_fall: assert property (
        @(posedge interface_clk) disable iff (!rstn_mac)
        $fell(tx_mgnt_valid) |-> $past(tx_mgnt_resp)
    ) else $error("tx_mgnt_valid fell without tx_mgnt_resp");

endmodule

bind mac_tx_gmii mac_tx_gmii_assertions u_assertions (
    .interface_clk (interface_clk),
    .rstn_mac      (rstn_mac),
    .data_fifo_rd  (data_fifo_rd),
    .tdata_fifo_rd (tdata_fifo_rd),
    .gtx_dv        (gtx_dv),
    .tx_mgnt_valid (tx_mgnt_valid),
    .tx_mgnt_resp  (tx_mgnt_resp)
);

/* tests/mac_tx_gmii_tb.sv */
`timescale 1ns/1ps

module mac_tx_gmii_tb;
    import mac_tx_pkg::*;

    localparam int max_vec = 32;

    logic        interface_clk;
    logic        rstn_mac;
    logic        gtx_dv;
    logic [7:0]  gtx_d;
    logic        data_fifo_rd;
    logic [7:0]  data_fifo_din;
    logic        ptr_fifo_rd;
    logic [15:0] ptr_fifo_din;
    logic        ptr_fifo_empty;
    logic        tdata_fifo_rd;
    logic [7:0]  tdata_fifo_din;
    logic        tptr_fifo_rd;
    logic [15:0] tptr_fifo_din;
    logic        tptr_fifo_empty;
    logic        tx_mgnt_valid;
    logic [15:0] tx_mgnt_data;
    logic        tx_mgnt_resp;

    // vector file, five words per line
    logic [31:0] vec_mem [0:5*max_vec-1];
    int          num_vec;
    // fifo model contents, index 1 is tte
    logic [7:0]  data_q [2][$];
    logic [15:0] ptr_q [2][$];
    // expected frames and reports in send order
    int          exp_frames[$];
    int          exp_reports[$];
    logic [7:0]  rx_bytes[$];
    int          frames_seen;
    int          frames_loaded;
    int          err_count;
    int          check_count;
    int          cycles;
    int          limit;
    int          gap_cnt;
    logic        prev_dv;
    logic        prev_valid;
    logic [3:0]  rd_seen;
    integer      seed;

    mac_tx_gmii uut (.*);

    ////////////////////
    // clock and timeout
    ////////////////////

    initial begin
        interface_clk = 1'b0;
        forever #10 interface_clk = ~interface_clk;
    end

    always @(posedge interface_clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("run stopped, no progress after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED %s got %08h expected %08h", name, got, exp);
        end
    endtask

    ////////////////////
    // fifo models
    ////////////////////

    // strobes taken mid cycle, acted on after the edge
    always @(negedge interface_clk) begin
        rd_seen = {tptr_fifo_rd, tdata_fifo_rd, ptr_fifo_rd, data_fifo_rd};
    end

    always @(posedge interface_clk) begin
        #2;
        for (int q = 0; q < 2; q++) begin
            if (rd_seen[2*q]) begin
                if (data_q[q].size() == 0) begin
                    err_count++;
                    $display("payload read from an empty data fifo, queue %0d", q);
                end else if (q == 0) begin
                    data_fifo_din = data_q[0].pop_front();
                end else begin
                    tdata_fifo_din = data_q[1].pop_front();
                end
            end
            if (rd_seen[2*q+1]) begin
                if (ptr_q[q].size() == 0) begin
                    err_count++;
                    $display("pointer read from an empty pointer fifo, queue %0d", q);
                end else if (q == 0) begin
                    ptr_fifo_din = ptr_q[0].pop_front();
                end else begin
                    tptr_fifo_din = ptr_q[1].pop_front();
                end
            end
        end
        ptr_fifo_empty  = (ptr_q[0].size() == 0);
        tptr_fifo_empty = (ptr_q[1].size() == 0);
    end

    // whole frame first, pointer last
    task automatic load_frame(input int v);
        int q;
        q = vec_mem[5*v];
        for (int i = 0; i < vec_mem[5*v+1]; i++) begin
            data_q[q].push_back(8'(vec_mem[5*v+2] + i));
        end
        ptr_q[q].push_back(16'(vec_mem[5*v+1]));
    endtask

    ////////////////////
    // management responder
    ////////////////////

    initial begin
        int   delay;
        int   v;
        logic [15:0] word;
        tx_mgnt_resp = 1'b0;
        forever begin
            @(negedge interface_clk);
            if (tx_mgnt_valid === 1'b1) begin
                word = tx_mgnt_data;
                if (exp_reports.size() == 0) begin
                    err_count++;
                    $display("management report with no frame expected");
                end else begin
                    v = exp_reports.pop_front();
                    check("tx_mgnt_data", 32'(word),
                          32'(vec_mem[5*v+1][11:0]) | (vec_mem[5*v] << (12 + mgnt_tte_bit)));
                end
                delay = 1 + ({$random(seed)} % 8);
                repeat (delay) begin
                    @(negedge interface_clk);
                    check("tx_mgnt_valid", 32'(tx_mgnt_valid), 32'h1);
                    check("tx_mgnt_data", 32'(tx_mgnt_data), 32'(word));
                end
                @(posedge interface_clk);
                #2 tx_mgnt_resp = 1'b1;
                @(posedge interface_clk);
                #2 tx_mgnt_resp = 1'b0;
                @(negedge interface_clk);
                check("tx_mgnt_valid", 32'(tx_mgnt_valid), 32'h0);
            end
        end
    end

    ////////////////////
    // gmii monitor
    ////////////////////

    task automatic check_frame();
        int v;
        int len;
        int errs_before;
        logic [7:0] exp;
        errs_before = err_count;
        if (exp_frames.size() == 0) begin
            err_count++;
            $display("frame sent with none expected");
        end else begin
            v = exp_frames.pop_front();
            len = vec_mem[5*v+1];
            check("gtx_dv length", 32'(rx_bytes.size()), 32'(8 + len + 4));
            for (int i = 0; i < rx_bytes.size() && i < 12 + len; i++) begin
                if (i < 7) exp = 8'h55;
                else if (i == 7) exp = 8'hd5;
                else if (i < 8 + len) exp = 8'(vec_mem[5*v+2] + i - 8);
                else exp = 8'(vec_mem[5*v+4] >> (8 * (i - 8 - len)));
                check("gtx_d", 32'(rx_bytes[i]), 32'(exp));
            end
            $display("frame %0d queue %0d len %0d %s", v, vec_mem[5*v], len,
                     (err_count == errs_before) ? "ok" : "with errors");
        end
        rx_bytes.delete();
        frames_seen++;
    endtask

    always @(negedge interface_clk) begin
        if (rstn_mac) begin
            if (gtx_dv) begin
                if (!prev_dv) begin
                    // gap and report hold off at frame start
                    if (frames_seen > 0 && gap_cnt < 12) begin
                        err_count++;
                        $display("only %0d idle cycles before frame", gap_cnt);
                    end
                    check("prior tx_mgnt_valid", 32'(prev_valid), 32'h0);
                    // report raised together with the first preamble byte
                    check("tx_mgnt_valid", 32'(tx_mgnt_valid), 32'h1);
                end
                rx_bytes.push_back(gtx_d);
            end else if (prev_dv) begin
                check_frame();
                gap_cnt = 1;
            end else begin
                gap_cnt++;
            end
        end
        prev_dv    = gtx_dv;
        prev_valid = tx_mgnt_valid;
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int k;
        seed = 32'h5500;
        rstn_mac = 1'b0;
        data_fifo_din = '0;
        tdata_fifo_din = '0;
        ptr_fifo_din = '0;
        tptr_fifo_din = '0;
        ptr_fifo_empty = 1'b1;
        tptr_fifo_empty = 1'b1;
        rd_seen = '0;
        prev_dv = 1'b0;
        prev_valid = 1'b0;
        limit = 0;
        for (int i = 0; i < 5 * max_vec; i++) vec_mem[i] = 32'hffff_ffff;
        $readmemh("tests/mac_tx_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < max_vec && vec_mem[5*num_vec] != 32'hffff_ffff) begin
            limit += vec_mem[5*num_vec+1] + 24 + 10;
            num_vec++;
        end
        limit += 100;
        if (num_vec == 0) begin
            $display("no vectors read from tests/mac_tx_vectors.txt");
            err_count++;
        end

        repeat (2) @(posedge interface_clk);
        #2 rstn_mac = 1'b1;

        // quiet outputs while both queues are empty
        repeat (4) begin
            @(negedge interface_clk);
            check("idle outputs", 32'({gtx_dv, data_fifo_rd, tdata_fifo_rd, ptr_fifo_rd,
                                       tptr_fifo_rd, tx_mgnt_valid}), 32'h0);
        end

        k = 0;
        while (k < num_vec) begin
            @(posedge interface_clk);
            #1;
            if (vec_mem[5*k+3] == 1 && k + 1 < num_vec) begin
                if (vec_mem[5*k] == vec_mem[5*(k+1)]) begin
                    err_count++;
                    $display("pair at vector %0d names the same queue twice", k);
                end
                load_frame(k);
                load_frame(k + 1);
                // tte frame leaves first
                if (vec_mem[5*k] == 1) begin
                    exp_frames.push_back(k);
                    exp_frames.push_back(k + 1);
                end else begin
                    exp_frames.push_back(k + 1);
                    exp_frames.push_back(k);
                end
                frames_loaded += 2;
                k += 2;
            end else begin
                load_frame(k);
                exp_frames.push_back(k);
                frames_loaded++;
                k++;
            end
            foreach (exp_frames[i]) begin
                if (i >= exp_frames.size() - (frames_loaded - frames_seen - exp_reports.size()))
                    exp_reports.push_back(exp_frames[i]);
            end
            while (frames_seen < frames_loaded) @(posedge interface_clk);
        end
        while (tx_mgnt_valid) @(posedge interface_clk);
        repeat (3) @(posedge interface_clk);

        // every frame must have produced its report
        check("pending reports", 32'(exp_reports.size()), 32'h0);

        $display("frames %0d, checks %0d, errors %0d", frames_seen, check_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/mac_tx_pkg.sv
logic/crc32_gen.sv
logic/tx_queue_arbiter.sv
logic/tx_frame_sequencer.sv
logic/tx_mgnt_report.sv
logic/mac_tx_gmii.sv
tests/mac_tx_gmii_assertions.sv
tests/mac_tx_gmii_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the mac tx testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module mac_tx_gmii_tb \
    -Mdir obj_dir -o sim_mac_tx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mac_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1

/* tests/mac_tx_vectors.txt */
// queue(0 best effort, 1 tte) length first_byte mode(0 solo, 1 pair) expected_crc
// pair loads this line and the next one together, in opposite queues
0 009 31 0 cbf43926
1 003 61 0 352441c2
0 001 61 1 e8b7be43
1 01a 61 0 4c2750bd
1 001 00 1 d202ef8d
0 001 ff 0 ff000000
0 01a 61 0 4c2750bd
